// ==== Bender.yml ====
package:
  name: bfp_encoder

sources:
  - files:
      - logic/bfp_pkg.sv
      - logic/bfp_ctrl_if.sv
      - logic/bfp_ctrl_fsm.sv
      - logic/beat_counter.sv
      - logic/block_buffer.sv
      - logic/magnitude_or_accum.sv
      - logic/leading_one_log2.sv
      - logic/mantissa_shifter.sv
      - logic/bfp_encoder_top.sv
  - target: test
    files:
      - tests/tb_bfp_encoder.sv

// ==== logic/beat_counter.sv ====
module beat_counter #(
  parameter int BLOCK_BEATS = 8
) (
  input  logic         clk,
  input  logic         rst_n,
  bfp_ctrl_if.counter  ctrl
);

  // Matches the index width inside the interface
  localparam int IDX_WIDTH = (BLOCK_BEATS > 1) ? $clog2(BLOCK_BEATS) : 1;
  localparam logic [IDX_WIDTH-1:0] LAST_IDX = IDX_WIDTH'(BLOCK_BEATS - 1);

  // One index serves as the write pointer in fill and the read pointer in drain
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ctrl.beat_idx <= '0;
    end else if (ctrl.count_clr) begin
      ctrl.beat_idx <= '0;
    end else if (ctrl.count_en) begin
      // Wrap explicitly so odd block sizes work too
      if (ctrl.beat_last) begin
        ctrl.beat_idx <= '0;
      end else begin
        ctrl.beat_idx <= ctrl.beat_idx + 1'b1;
      end
    end
  end

  // The accumulator loads instead of ORing on this beat
  assign ctrl.first_beat = (ctrl.beat_idx == '0);

  // Ends the fill and marks out_last during drain
  assign ctrl.beat_last = (ctrl.beat_idx == LAST_IDX);

  // The index has to stay inside the buffer depth
  assert property (@(posedge clk) disable iff (!rst_n)
    ctrl.beat_idx < BLOCK_BEATS);

endmodule

// ==== logic/bfp_ctrl_fsm.sv ====
module bfp_ctrl_fsm (
  input  logic         clk,
  input  logic         rst_n,
  input  logic         in_valid,
  output logic         in_ready,
  output logic         out_valid,
  input  logic         out_ready,
  bfp_ctrl_if.fsm      ctrl
);

  // FILL takes the input beats, EXP settles the shared exponent,
  // DRAIN hands out the mantissas
  typedef enum logic [1:0] {
    FILL,
    EXP,
    DRAIN
  } state_t;

  state_t state;
  state_t state_next;
  logic   in_fire;
  logic   out_fire;

  // Only one block is in flight, so each side is ready in its own state only
  assign in_ready  = (state == FILL);
  assign out_valid = (state == DRAIN);

  assign in_fire  = in_valid && in_ready;
  assign out_fire = out_valid && out_ready;

  // Every accepted input beat lands in the buffer and the accumulator
  assign ctrl.fill_en = in_fire;

  // The index moves on each transfer at either end
  assign ctrl.count_en = in_fire || out_fire;

  // EXP is a single cycle that latches the exponent and rewinds the index
  assign ctrl.count_clr = (state == EXP);
  assign ctrl.exp_latch = (state == EXP);

  always_comb begin
    state_next = state;
    case (state)
      FILL: begin
        // The last accepted beat completes the block
        if (in_fire && ctrl.beat_last) begin
          state_next = EXP;
        end
      end
      EXP: begin
        state_next = DRAIN;
      end
      DRAIN: begin
        // Input opens again once the final mantissa beat is taken
        if (out_fire && ctrl.beat_last) begin
          state_next = FILL;
        end
      end
      default: begin
        state_next = FILL;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= FILL;
    end else begin
      state <= state_next;
    end
  end

  // An offered output beat may not be withdrawn before it is taken
  assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid);

  // Fill and drain never overlap
  assert property (@(posedge clk) disable iff (!rst_n)
    !(in_ready && out_valid));

endmodule

// ==== logic/bfp_ctrl_if.sv ====
interface bfp_ctrl_if #(
  parameter int BLOCK_BEATS = 8
);

  // A single beat block still needs one index bit
  localparam int IDX_WIDTH = (BLOCK_BEATS > 1) ? $clog2(BLOCK_BEATS) : 1;

  // Beat position inside the block, shared by fill and drain
  logic [IDX_WIDTH-1:0] beat_idx;
  // High on the final beat of a block
  logic                 beat_last;
  // High on the opening beat of a block
  logic                 first_beat;

  // Counter controls from the FSM
  logic                 count_en;
  logic                 count_clr;

  // Datapath strobes from the FSM
  logic                 fill_en;
  logic                 exp_latch;

  modport fsm (input beat_last, output count_en, count_clr, fill_en, exp_latch);

  modport counter (input count_en, count_clr, output beat_idx, beat_last, first_beat);

  modport datapath (input beat_idx, first_beat, fill_en, exp_latch);

endinterface

// ==== logic/bfp_encoder_top.sv ====
module bfp_encoder_top #(
  parameter int LANES       = 4,
  parameter int BLOCK_BEATS = 8
) (
  input  logic              clk,
  input  logic              rst_n,
  input  bfp_pkg::sample_t  in_data [LANES],
  input  logic              in_valid,
  output logic              in_ready,
  output bfp_pkg::mant_t    out_mant [LANES],
  output bfp_pkg::exp_t     out_exp,
  output logic              out_last,
  output logic              out_valid,
  input  logic              out_ready
);

  import bfp_pkg::*;

  // Buffered beat at the current index
  sample_t rd_data [LANES];
  // Block wide OR of the lane magnitudes
  sample_t mag_or;
  // Registered right shift for the drain
  exp_t    shift;

  bfp_ctrl_if #(.BLOCK_BEATS(BLOCK_BEATS)) ctrl_if ();

  bfp_ctrl_fsm u_fsm (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .ctrl      (ctrl_if.fsm)
  );

  beat_counter #(.BLOCK_BEATS(BLOCK_BEATS)) u_counter (
    .clk   (clk),
    .rst_n (rst_n),
    .ctrl  (ctrl_if.counter)
  );

  block_buffer #(.LANES(LANES), .BLOCK_BEATS(BLOCK_BEATS)) u_buffer (
    .clk     (clk),
    .in_data (in_data),
    .rd_data (rd_data),
    .ctrl    (ctrl_if.datapath)
  );

  magnitude_or_accum #(.LANES(LANES)) u_accum (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_data (in_data),
    .mag_or  (mag_or),
    .ctrl    (ctrl_if.datapath)
  );

  // Its registered exponent drives out_exp directly
  leading_one_log2 u_log2 (
    .clk    (clk),
    .rst_n  (rst_n),
    .mag_or (mag_or),
    .exp    (out_exp),
    .shift  (shift),
    .ctrl   (ctrl_if.datapath)
  );

  mantissa_shifter #(.LANES(LANES)) u_shifter (
    .clk      (clk),
    .valid    (out_valid),
    .rd_data  (rd_data),
    .shift    (shift),
    .out_mant (out_mant)
  );

  // The counter already flags the final beat of the drain
  assign out_last = ctrl_if.beat_last;

endmodule

// ==== logic/bfp_pkg.sv ====
package bfp_pkg;

  // Input samples are two's complement at this width
  localparam int SAMPLE_WIDTH = 16;

  // Output mantissas are two's complement at this width
  localparam int MANT_WIDTH = 8;

  // One extra bit so that an exponent equal to SAMPLE_WIDTH still fits.
  // With 16 bit samples the exponent runs from 0 to 16
  localparam int EXP_WIDTH = $clog2(SAMPLE_WIDTH) + 1;

  // One input sample.
  // The same type holds unsigned magnitudes and their OR
  typedef logic [SAMPLE_WIDTH-1:0] sample_t;

  // One output mantissa
  typedef logic [MANT_WIDTH-1:0] mant_t;

  // Shared block exponent, also used for the right shift amount
  typedef logic [EXP_WIDTH-1:0] exp_t;

endpackage

// ==== logic/block_buffer.sv ====
module block_buffer #(
  parameter int LANES       = 4,
  parameter int BLOCK_BEATS = 8
) (
  input  logic              clk,
  input  bfp_pkg::sample_t  in_data [LANES],
  output bfp_pkg::sample_t  rd_data [LANES],
  bfp_ctrl_if.datapath      ctrl
);

  import bfp_pkg::*;

  // One entry per beat, each entry holds all lanes of that beat
  sample_t mem [BLOCK_BEATS][LANES];

  // Entries are written in beat order while the block fills
  always_ff @(posedge clk) begin
    if (ctrl.fill_en) begin
      for (int lane = 0; lane < LANES; lane++) begin
        mem[ctrl.beat_idx][lane] <= in_data[lane];
      end
    end
  end

  // Asynchronous read at the current index.
  // During drain the counter walks the entries in the same order
  always_comb begin
    for (int lane = 0; lane < LANES; lane++) begin
      rd_data[lane] = mem[ctrl.beat_idx][lane];
    end
  end

endmodule

// ==== logic/leading_one_log2.sv ====
module leading_one_log2 (
  input  logic              clk,
  input  logic              rst_n,
  input  bfp_pkg::sample_t  mag_or,
  output bfp_pkg::exp_t     exp,
  output bfp_pkg::exp_t     shift,
  bfp_ctrl_if.datapath      ctrl
);

  import bfp_pkg::*;

  localparam exp_t MANT_SPAN = exp_t'(MANT_WIDTH - 1);

  exp_t exp_next;
  exp_t shift_next;

  // Priority encoder, the highest set bit wins since it is visited last.
  // A zero input leaves the default of 0
  always_comb begin
    exp_next = '0;
    for (int bit_pos = 0; bit_pos < SAMPLE_WIDTH; bit_pos++) begin
      if (mag_or[bit_pos]) begin
        exp_next = exp_t'(bit_pos + 1);
      end
    end
  end

  // Small blocks already fit the mantissa and are not shifted
  assign shift_next = (exp_next > MANT_SPAN) ? exp_next - MANT_SPAN : '0;

  // Both stay fixed for the whole drain
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      exp   <= '0;
      shift <= '0;
    end else if (ctrl.exp_latch) begin
      exp   <= exp_next;
      shift <= shift_next;
    end
  end

  // The exponent never passes the sample width
  assert property (@(posedge clk) disable iff (!rst_n)
    exp <= exp_t'(SAMPLE_WIDTH));

endmodule

// ==== logic/magnitude_or_accum.sv ====
module magnitude_or_accum #(
  parameter int LANES = 4
) (
  input  logic              clk,
  input  logic              rst_n,
  input  bfp_pkg::sample_t  in_data [LANES],
  output bfp_pkg::sample_t  mag_or,
  bfp_ctrl_if.datapath      ctrl
);

  import bfp_pkg::*;

  sample_t lane_mag [LANES];
  sample_t beat_or;

  // Two's complement magnitude per lane, read as unsigned.
  // The most negative sample maps to a lone top bit, which is its true magnitude
  always_comb begin
    for (int lane = 0; lane < LANES; lane++) begin
      if (in_data[lane][SAMPLE_WIDTH-1]) begin
        lane_mag[lane] = ~in_data[lane] + 1'b1;
      end else begin
        lane_mag[lane] = in_data[lane];
      end
    end
  end

  // The OR keeps every bit position that any lane reaches.
  // Its top set bit is the same as that of the largest magnitude
  always_comb begin
    beat_or = '0;
    for (int lane = 0; lane < LANES; lane++) begin
      beat_or = beat_or | lane_mag[lane];
    end
  end

  // Accumulate over the block.
  // The opening beat replaces the previous block's result
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mag_or <= '0;
    end else if (ctrl.fill_en) begin
      if (ctrl.first_beat) begin
        mag_or <= beat_or;
      end else begin
        mag_or <= mag_or | beat_or;
      end
    end
  end

endmodule

// ==== logic/mantissa_shifter.sv ====
module mantissa_shifter #(
  parameter int LANES = 4
) (
  input  logic              clk,
  input  logic              valid,
  input  bfp_pkg::sample_t  rd_data [LANES],
  input  bfp_pkg::exp_t     shift,
  output bfp_pkg::mant_t    out_mant [LANES]
);

  import bfp_pkg::*;

  sample_t shifted [LANES];

  for (genvar lane = 0; lane < LANES; lane++) begin : g_lane
    // Arithmetic shift keeps the sign of the sample
    assign shifted[lane] = sample_t'($signed(rd_data[lane]) >>> shift);

    // Truncate to the low bits, no rounding
    assign out_mant[lane] = mant_t'(shifted[lane]);

    // Bits above the mantissa must all copy its sign bit.
    // This only holds while the buffer and the shift belong to the same block
    assert property (@(posedge clk)
      valid |-> (shifted[lane][SAMPLE_WIDTH-1:MANT_WIDTH-1] == '0) ||
                (shifted[lane][SAMPLE_WIDTH-1:MANT_WIDTH-1] == '1));
  end

endmodule

// ==== tb.f ====
logic/bfp_pkg.sv
logic/bfp_ctrl_if.sv
logic/bfp_ctrl_fsm.sv
logic/beat_counter.sv
logic/block_buffer.sv
logic/magnitude_or_accum.sv
logic/leading_one_log2.sv
logic/mantissa_shifter.sv
logic/bfp_encoder_top.sv
tests/tb_bfp_encoder.sv

// ==== tests/tb_bfp_encoder.sv ====
module tb_bfp_encoder;

  import bfp_pkg::*;

  localparam int LANES        = 4;
  localparam int BLOCK_BEATS  = 8;
  localparam int MODE_RANDOM  = 0;
  localparam int MODE_ZERO    = 1;
  localparam int MODE_EXTREME = 2;
  // Block counts of the four tests, summed for the watchdog
  localparam int TOTAL_BLOCKS = 20 + 2 + 4 + 10;
  localparam int TIMEOUT = (TOTAL_BLOCKS * (2 * BLOCK_BEATS * 4 + 10) + 10) * 10;

  logic    clk;
  logic    rst_n;
  sample_t in_data [LANES];
  logic    in_valid;
  logic    in_ready;
  mant_t   out_mant [LANES];
  exp_t    out_exp;
  logic    out_last;
  logic    out_valid;
  logic    out_ready;

  // Lanes packed side by side so that whole beats compare in one step
  logic [LANES*MANT_WIDTH-1:0] out_mant_flat;

  // Reference model state, one block gathered from accepted input beats
  sample_t blk [BLOCK_BEATS][LANES];
  int      in_cnt = 0;
  logic    in_last;
  exp_t    exp_q [$];
  logic [LANES*MANT_WIDTH-1:0] mant_q [$];
  logic    last_q [$];

  // Front of the expected queues, seen by the assertions
  logic    have_exp = 1'b0;
  exp_t    exp_head = '0;
  logic [LANES*MANT_WIDTH-1:0] mant_head = '0;
  logic    last_head = 1'b0;

  string   test_name = "reset";
  int      hold_pct = 0;
  int      errors = 0;
  int      out_beats = 0;
  int      tests_run = 0;
  int      tests_passed = 0;
  int      tests_failed = 0;
  logic    seen_exp16 = 1'b0;

  bfp_encoder_top #(.LANES(LANES), .BLOCK_BEATS(BLOCK_BEATS)) dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_mant  (out_mant),
    .out_exp   (out_exp),
    .out_last  (out_last),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always_comb begin
    for (int l = 0; l < LANES; l++) begin
      out_mant_flat[l*MANT_WIDTH +: MANT_WIDTH] = out_mant[l];
    end
  end

  assign in_last = (in_cnt == BLOCK_BEATS - 1);

  // Unsigned magnitude of a two's complement sample, 32768 included
  function automatic int magnitude(input sample_t s);
    int v;
    v = int'($signed(s));
    return (v < 0) ? -v : v;
  endfunction

  // Shared exponent, shift and mantissas of the gathered block
  task automatic push_expected();
    int acc;
    int e;
    int sh;
    int v;
    logic [LANES*MANT_WIDTH-1:0] m;
    acc = 0;
    for (int b = 0; b < BLOCK_BEATS; b++) begin
      for (int l = 0; l < LANES; l++) begin
        acc = acc | magnitude(blk[b][l]);
      end
    end
    // Smallest e with acc below 2**e, which is the top set bit plus one
    e = 0;
    while ((acc >> e) != 0) begin
      e++;
    end
    sh = (e > MANT_WIDTH - 1) ? e - (MANT_WIDTH - 1) : 0;
    for (int b = 0; b < BLOCK_BEATS; b++) begin
      for (int l = 0; l < LANES; l++) begin
        v = int'($signed(blk[b][l])) >>> sh;
        m[l*MANT_WIDTH +: MANT_WIDTH] = v[MANT_WIDTH-1:0];
      end
      exp_q.push_back(exp_t'(e));
      mant_q.push_back(m);
      last_q.push_back(b == BLOCK_BEATS - 1);
    end
  endtask

  // Follows both handshakes and keeps the expected queues in step
  always @(posedge clk) begin
    if (rst_n && in_valid && in_ready) begin
      for (int l = 0; l < LANES; l++) begin
        blk[in_cnt][l] = in_data[l];
      end
      if (in_last) begin
        push_expected();
        in_cnt = 0;
      end else begin
        in_cnt++;
      end
    end
    if (rst_n && out_valid && out_ready) begin
      // The DUT itself has to deliver the top exponent at least once
      if (out_exp == exp_t'(16)) seen_exp16 = 1'b1;
      if (exp_q.size() != 0) begin
        void'(exp_q.pop_front());
        void'(mant_q.pop_front());
        void'(last_q.pop_front());
      end
      out_beats++;
    end
    have_exp = (exp_q.size() != 0);
    if (have_exp) begin
      exp_head  = exp_q[0];
      mant_head = mant_q[0];
      last_head = last_q[0];
    end
  end

  // Back-pressure pattern, redrawn every cycle
  always @(posedge clk) begin
    #1;
    out_ready = ($urandom_range(0, 99) >= hold_pct);
  end

  a_exp: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && out_ready && have_exp |-> out_exp == exp_head)
    else begin
      errors++;
      $display("mismatch %s out_exp expected %0d actual %0d", test_name,
               $sampled(exp_head), $sampled(out_exp));
    end

  a_mant: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && out_ready && have_exp |-> out_mant_flat == mant_head)
    else begin
      errors++;
      $display("mismatch %s out_mant expected %h actual %h", test_name,
               $sampled(mant_head), $sampled(out_mant_flat));
    end

  a_last: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && out_ready && have_exp |-> out_last == last_head)
    else begin
      errors++;
      $display("mismatch %s out_last expected %0d actual %0d", test_name,
               $sampled(last_head), $sampled(out_last));
    end

  a_extra: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && out_ready |-> have_exp)
    else begin
      errors++;
      $display("output beat accepted with no block pending in test %s", test_name);
    end

  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_mant_flat) &&
                               $stable(out_exp) && $stable(out_last))
    else begin
      errors++;
      $display("outputs changed under back-pressure in test %s", test_name);
    end

  a_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(in_ready && out_valid))
    else begin
      errors++;
      $display("in_ready and out_valid high together in test %s", test_name);
    end

  a_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> in_ready && !out_valid)
    else begin
      errors++;
      $display("wrong handshake state after reset release");
    end

  // Two cycle latency from the last accepted input beat to out_valid
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && in_ready && in_last |=> !out_valid ##1 out_valid)
    else begin
      errors++;
      $display("out_valid missed its 2 cycle latency in test %s", test_name);
    end

  function automatic sample_t make_sample(input int mode, input int k, input int b,
                                          input int l, input int lim);
    int      mag;
    sample_t s;
    if (mode == MODE_ZERO) begin
      s = '0;
    end else if (mode == MODE_EXTREME) begin
      case (k % 4)
        0: s = (b == 3 && l == 2) ? 16'h8000 : sample_t'($urandom);
        1: s = 16'h7fff;
        2: s = ((b + l) % 2 != 0) ? 16'hffff : 16'h0001;
        default: s = (l == 0) ? 16'h8000 : ((b % 2 != 0) ? 16'h007f : 16'hff80);
      endcase
    end else if (lim >= SAMPLE_WIDTH) begin
      s = sample_t'($urandom);
    end else begin
      // Magnitude below 2**lim, so the block exponent is at most lim
      mag = $urandom & ((1 << lim) - 1);
      s = ($urandom_range(0, 1) != 0) ? sample_t'(-mag) : sample_t'(mag);
    end
    return s;
  endfunction

  // Sends one block, starting and ending 1 time unit after a rising edge
  task automatic send_block(input int mode, input int k);
    int lim;
    lim = $urandom_range(0, SAMPLE_WIDTH);
    for (int b = 0; b < BLOCK_BEATS; b++) begin
      while ($urandom_range(0, 3) == 0) begin
        @(posedge clk);
        #1;
      end
      for (int l = 0; l < LANES; l++) begin
        in_data[l] = make_sample(mode, k, b, l, lim);
      end
      in_valid = 1'b1;
      @(posedge clk);
      while (!in_ready) @(posedge clk);
      #1;
      in_valid = 1'b0;
    end
  endtask

  task automatic run_test(input string name, input int nblocks, input int mode,
                          input int hold);
    int err_start;
    int beats_start;
    err_start   = errors;
    beats_start = out_beats;
    test_name   = name;
    hold_pct    = hold;
    for (int k = 0; k < nblocks; k++) begin
      send_block(mode, k);
    end
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
    end
    if (out_beats - beats_start != nblocks * BLOCK_BEATS) begin
      errors++;
      $display("mismatch %s output beats expected %0d actual %0d", name,
               nblocks * BLOCK_BEATS, out_beats - beats_start);
    end
    tests_run++;
    if (errors == err_start) tests_passed++;
    else tests_failed++;
    $display("test %s finished with %0d blocks and %0d errors", name, nblocks,
             errors - err_start);
  endtask

  // Watchdog sized from the block count of all tests
  initial begin
    #(TIMEOUT);
    $display("timeout, the DUT stopped making progress in test %s", test_name);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h66f86c69));
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    out_ready = 1'b0;
    for (int l = 0; l < LANES; l++) begin
      in_data[l] = '0;
    end
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    run_test("random_blocks", 20, MODE_RANDOM, 40);
    run_test("zero_block", 2, MODE_ZERO, 40);
    run_test("extreme_values", 4, MODE_EXTREME, 40);
    run_test("back_pressure", 10, MODE_RANDOM, 75);
    // The extreme test holds a block of -32768 samples
    if (!seen_exp16) begin
      errors++;
      $display("no output block carried exponent 16");
    end
    $display("tests run %0d, passed %0d, failed %0d, errors %0d", tests_run,
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
